//--- dv/fg_tests.txt
# one command per line: L mode (0 marker, 1 prbs), W address data (hex),
# D wait for loaded, I idle cycles, C number of words to check
C 2048
W 005 a5
W 3ff 3c
W 200 81
W 021 00
C 1024
I 37
L 1
D
C 1100
W 0ff 11
C 1024
L 0
I 300
W 010 5a
D
C 40
I 5
L 1
I 3
L 0
D
C 64

//--- dv/function_generator_tb.sv
module function_generator_tb
	import fg_data_pkg::*;
	import fg_control_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int WORD_GAP = 8;

	logic clock = 1'b0;
	logic reset;
	logic load_strobe;
	pattern_mode_t load_mode;
	logic host_write_strobe;
	address_t host_address;
	sample_t host_data;
	logic bit_out;
	sample_t word_out;
	logic word_strobe;
	logic loading;
	logic loaded;

	// expected memory contents and playback position
	sample_t model [MEMORY_WORDS];
	int model_address;
	int cycle;
	int last_strobe;
	int loaded_cycle;
	int fill_cycles;
	int strobe_count;
	sample_t pending_bits;
	int bits_left;
	logic fill_done;
	logic timed_out;
	int error_count;
	int check_count;

	function_generator_top function_generator_top_inst (
		.clock(clock),
		.reset(reset),
		.load_strobe(load_strobe),
		.load_mode(load_mode),
		.host_write_strobe(host_write_strobe),
		.host_address(host_address),
		.host_data(host_data),
		.bit_out(bit_out),
		.word_out(word_out),
		.word_strobe(word_strobe),
		.loading(loading),
		.loaded(loaded)
	);

	always #5 clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	// frame of 32: flag, frame number, offset, flag, zeros
	function automatic sample_t marker_word(input int address);
		case (address % 32)
			0, 3: return 8'hff;
			1: return sample_t'(address / 32);
			2: return sample_t'(address % 32);
			default: return 8'h00;
		endcase
	endfunction

	task automatic fill_model(input int mode);
		logic [30:0] lfsr;
		lfsr = PRBS_SEED;
		for (int a = 0; a < MEMORY_WORDS; a++) begin
			if (mode == 1) begin
				model[a] = lfsr[7:0];
				// x^31 + x^28 + 1, eight fresh bits per word
				repeat (8) lfsr = {lfsr[29:0], lfsr[30] ^ lfsr[27]};
			end else begin
				model[a] = marker_word(a);
			end
		end
	endtask

	// sample at the falling edge, return at the drive point after the next rise
	task automatic next_cycle();
		@(negedge clock);
		cycle++;
		if (loading) begin
			fill_cycles++;
			bits_left = 0;
			last_strobe = -1;
			check_value("word_strobe", 32'(word_strobe), 0);
			check_value("bit_out", 32'(bit_out), 0);
			check_value("word_out", 32'(word_out), 0);
		end
		if (word_strobe) begin
			check_value("word_out", 32'(word_out), 32'(model[model_address]));
			// first word two cycles after loaded, then a fixed gap
			if (last_strobe < 0) begin
				check_value("first strobe delay", cycle - loaded_cycle, 2);
			end else begin
				check_value("strobe gap", cycle - last_strobe, WORD_GAP);
			end
			last_strobe = cycle;
			pending_bits = model[model_address];
			bits_left = SAMPLE_BITS;
			model_address = (model_address + 1) % MEMORY_WORDS;
			strobe_count++;
		end
		// msb first, starting in the strobe cycle
		if (bits_left > 0) begin
			check_value("bit_out", 32'(bit_out), 32'(pending_bits[SAMPLE_BITS-1]));
			pending_bits = pending_bits << 1;
			bits_left--;
		end
		if (loaded) begin
			check_value("loading", 32'(loading), 0);
			check_value("fill cycles", fill_cycles, MEMORY_WORDS);
			fill_cycles = 0;
			model_address = 0;
			loaded_cycle = cycle;
			last_strobe = -1;
			fill_done = 1'b1;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic wait_for_strobe();
		int start;
		start = strobe_count;
		for (int i = 0; i < TIMEOUT_CYCLES && strobe_count == start; i++) begin
			next_cycle();
		end
		if (strobe_count == start) begin
			$display("timeout: no word_strobe within %0d cycles", TIMEOUT_CYCLES);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_for_loaded();
		for (int i = 0; i < TIMEOUT_CYCLES && !fill_done; i++) begin
			next_cycle();
		end
		if (!fill_done) begin
			$display("timeout: loaded never pulsed within %0d cycles", TIMEOUT_CYCLES);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic start_load(input int mode);
		load_strobe = 1'b1;
		load_mode = pattern_mode_t'(mode);
		next_cycle();
		load_strobe = 1'b0;
		// old contents still valid for a word in the strobe cycle
		fill_model(mode);
		fill_done = 1'b0;
		fill_cycles = 0;
	endtask

	// during playback, write just after a word so the next read sees it
	task automatic host_write(input int address, input int data);
		if (!loading) begin
			wait_for_strobe();
		end
		host_write_strobe = 1'b1;
		host_address = address_t'(address);
		host_data = sample_t'(data);
		// dropped by the memory while a fill runs
		if (!loading) begin
			model[address] = sample_t'(data);
		end
		next_cycle();
		host_write_strobe = 1'b0;
	endtask

	initial begin
		int fd;
		int code;
		int arg_a;
		int arg_b;
		logic [7:0] command;
		logic [8*160-1:0] rest;
		reset = 1'b1;
		load_strobe = 1'b0;
		load_mode = mode_marker;
		host_write_strobe = 1'b0;
		host_address = '0;
		host_data = '0;
		model_address = 0;
		cycle = 0;
		last_strobe = -1;
		loaded_cycle = 0;
		fill_cycles = 0;
		strobe_count = 0;
		pending_bits = '0;
		bits_left = 0;
		fill_done = 1'b0;
		timed_out = 1'b0;
		error_count = 0;
		check_count = 0;
		// power-up fill is always the marker pattern
		fill_model(0);
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		check_value("loading", 32'(loading), 1);
		check_value("loaded", 32'(loaded), 0);
		check_value("word_strobe", 32'(word_strobe), 0);
		check_value("word_out", 32'(word_out), 0);
		check_value("bit_out", 32'(bit_out), 0);
		wait_for_loaded();
		fd = $fopen("dv/fg_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file dv/fg_tests.txt");
			error_count++;
		end else begin
			code = $fscanf(fd, " %c", command);
			while (code == 1 && !timed_out) begin
				case (command)
					"#": code = $fgets(rest, fd);
					"L": begin
						code = $fscanf(fd, "%d", arg_a);
						start_load(arg_a);
					end
					"W": begin
						code = $fscanf(fd, "%h %h", arg_a, arg_b);
						host_write(arg_a, arg_b);
					end
					"D": wait_for_loaded();
					"I": begin
						code = $fscanf(fd, "%d", arg_a);
						repeat (arg_a) next_cycle();
					end
					"C": begin
						code = $fscanf(fd, "%d", arg_a);
						for (int n = 0; n < arg_a && !timed_out; n++) begin
							wait_for_strobe();
						end
					end
					default: begin
						$display("unknown command %c in the test file", command);
						error_count++;
					end
				endcase
				code = $fscanf(fd, " %c", command);
			end
			$fclose(fd);
		end
		$display("errors %0d, checks %0d", error_count, check_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- files.f
logic/fg_data_pkg.sv
logic/fg_control_pkg.sv
logic/prbs_generator.sv
logic/pattern_loader.sv
logic/waveform_memory.sv
logic/word_serializer.sv
logic/function_generator_top.sv
dv/function_generator_tb.sv

//--- logic/fg_control_pkg.sv
package fg_control_pkg;

	// what the loader writes into the memory
	typedef enum logic {
		// address-marker frames, 32 words each
		mode_marker,
		// bytes from the prbs-31 source
		mode_prbs
	} pattern_mode_t;

	// loader fsm
	typedef enum logic [1:0] {
		// memory full, playback running
		idle,
		// one write per clock
		fill,
		// single cycle, raises loaded
		done_pulse
	} loader_state_t;

endpackage

//--- logic/fg_data_pkg.sv
package fg_data_pkg;

	// one waveform word, also the serializer ratio
	localparam int SAMPLE_BITS = 8;

	// memory depth and address width
	localparam int ADDRESS_BITS = 10;
	localparam int MEMORY_WORDS = 1 << ADDRESS_BITS;

	typedef logic [SAMPLE_BITS-1:0] sample_t;
	typedef logic [ADDRESS_BITS-1:0] address_t;

	// bit position inside the current word, counts 0 to SAMPLE_BITS-1
	typedef logic [$clog2(SAMPLE_BITS)-1:0] phase_t;

	// marker frame repeats every 32 addresses
	localparam int MARKER_FIELD_BITS = 5;
	localparam sample_t MARKER_FLAG = 8'hff;

	// prbs-31, polynomial x^31 + x^28 + 1
	localparam int PRBS_BITS = 31;
	localparam int PRBS_TAP_HIGH = 31;
	localparam int PRBS_TAP_LOW = 28;

	typedef logic [PRBS_BITS-1:0] prbs_state_t;

	// any nonzero start works; all ones is the usual choice
	localparam prbs_state_t PRBS_SEED = '1;

endpackage

//--- logic/function_generator_top.sv
module function_generator_top
	import fg_data_pkg::*;
	import fg_control_pkg::*;
#(
	// words filled and played before wrapping, 2 to MEMORY_WORDS
	parameter int PLAYBACK_WORDS = MEMORY_WORDS
) (
	input logic clock,
	input logic reset,
	input logic load_strobe,
	input pattern_mode_t load_mode,
	input logic host_write_strobe,
	input address_t host_address,
	input sample_t host_data,
	output logic bit_out,
	output sample_t word_out,
	output logic word_strobe,
	output logic loading,
	output logic loaded
);

	// loader side
	logic prbs_restart;
	logic prbs_advance;
	sample_t prbs_byte;
	logic fill_strobe;
	address_t fill_address;
	sample_t fill_data;

	// playback side
	logic word_request;
	logic read_strobe;
	sample_t read_data;

	// every fill in prbs mode starts from the seed
	assign prbs_restart = reset || load_strobe;

	prbs_generator prbs_generator_inst (
		.clock(clock),
		.reset(reset),
		.restart(prbs_restart),
		.prbs_advance(prbs_advance),
		.prbs_byte(prbs_byte)
	);

	pattern_loader #(
		.PLAYBACK_WORDS(PLAYBACK_WORDS)
	) pattern_loader_inst (
		.clock(clock),
		.reset(reset),
		.load_strobe(load_strobe),
		.load_mode(load_mode),
		.prbs_byte(prbs_byte),
		.prbs_advance(prbs_advance),
		.fill_strobe(fill_strobe),
		.fill_address(fill_address),
		.fill_data(fill_data),
		.loading(loading),
		.loaded(loaded)
	);

	waveform_memory #(
		.PLAYBACK_WORDS(PLAYBACK_WORDS)
	) waveform_memory_inst (
		.clock(clock),
		.reset(reset),
		.fill_strobe(fill_strobe),
		.fill_address(fill_address),
		.fill_data(fill_data),
		.host_write_strobe(host_write_strobe),
		.host_address(host_address),
		.host_data(host_data),
		.loading(loading),
		.word_request(word_request),
		.read_strobe(read_strobe),
		.read_data(read_data)
	);

	// one bit per clock, msb first
	word_serializer word_serializer_inst (
		.clock(clock),
		.reset(reset),
		.loading(loading),
		.read_strobe(read_strobe),
		.read_data(read_data),
		.word_request(word_request),
		.word_strobe(word_strobe),
		.word_out(word_out),
		.bit_out(bit_out)
	);

endmodule

//--- logic/pattern_loader.sv
module pattern_loader
	import fg_data_pkg::*;
	import fg_control_pkg::*;
#(
	parameter int PLAYBACK_WORDS = MEMORY_WORDS
) (
	input logic clock,
	input logic reset,
	input logic load_strobe,
	input pattern_mode_t load_mode,
	input sample_t prbs_byte,
	output logic prbs_advance,
	output logic fill_strobe,
	output address_t fill_address,
	output sample_t fill_data,
	output logic loading,
	output logic loaded
);

	// fill stops here
	localparam address_t LAST_ADDRESS = address_t'(PLAYBACK_WORDS - 1);

	loader_state_t state;
	pattern_mode_t fill_mode;
	sample_t marker_data;

	// reset and load strobe both restart the fill at address 0
	// mode is captured once so a change mid-fill does not mix patterns
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fill;
			fill_address <= '0;
			fill_mode <= mode_marker;
		end else if (load_strobe) begin
			state <= fill;
			fill_address <= '0;
			fill_mode <= load_mode;
		end else begin
			case (state)
				fill: begin
					if (fill_address == LAST_ADDRESS) begin
						state <= done_pulse;
						fill_address <= '0;
					end else begin
						fill_address <= fill_address + 1'b1;
					end
				end
				done_pulse: begin
					state <= idle;
				end
				default: begin
					// idle until the next load
					state <= idle;
				end
			endcase
		end
	end

	// marker frame of 32 words
	// flag, frame number, offset, flag, then zeros
	always_comb begin
		case (fill_address[MARKER_FIELD_BITS-1:0])
			5'd0, 5'd3: begin
				marker_data = MARKER_FLAG;
			end
			5'd1: begin
				marker_data = sample_t'(fill_address[ADDRESS_BITS-1:MARKER_FIELD_BITS]);
			end
			5'd2: begin
				marker_data = sample_t'(fill_address[MARKER_FIELD_BITS-1:0]);
			end
			default: begin
				marker_data = '0;
			end
		endcase
	end

	assign fill_strobe = (state == fill);
	assign loading = (state == fill);
	// loading drops in the same cycle
	assign loaded = (state == done_pulse);

	// one prbs byte consumed per word written
	assign prbs_advance = fill_strobe && (fill_mode == mode_prbs);
	assign fill_data = (fill_mode == mode_prbs) ? prbs_byte : marker_data;

endmodule

//--- logic/prbs_generator.sv
module prbs_generator
	import fg_data_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic restart,
	input logic prbs_advance,
	output sample_t prbs_byte
);

	prbs_state_t state;

	// fibonacci lfsr, SAMPLE_BITS steps unrolled
	// new bits enter at the bottom, so the low byte is all fresh
	function automatic prbs_state_t prbs_step_word(input prbs_state_t current);
		prbs_state_t next;
		next = current;
		for (int i = 0; i < SAMPLE_BITS; i++) begin
			next = {next[PRBS_BITS-2:0], next[PRBS_TAP_HIGH-1] ^ next[PRBS_TAP_LOW-1]};
		end
		return next;
	endfunction

	always_ff @(posedge clock) begin
		if (reset || restart) begin
			state <= PRBS_SEED;
		end else if (prbs_advance) begin
			state <= prbs_step_word(state);
		end
	end

	// byte for the current write, next one ready after the advance
	assign prbs_byte = state[SAMPLE_BITS-1:0];

	// all-zero state would lock the register up for good
	state_nonzero: assert property (
		@(posedge clock) disable iff (reset)
		state != '0
	) else $error("prbs state collapsed to zero");

endmodule

//--- logic/waveform_memory.sv
module waveform_memory
	import fg_data_pkg::*;
#(
	parameter int PLAYBACK_WORDS = MEMORY_WORDS
) (
	input logic clock,
	input logic reset,
	input logic fill_strobe,
	input address_t fill_address,
	input sample_t fill_data,
	input logic host_write_strobe,
	input address_t host_address,
	input sample_t host_data,
	input logic loading,
	input logic word_request,
	output logic read_strobe,
	output sample_t read_data
);

	// playback wraps after this address
	localparam address_t LAST_ADDRESS = address_t'(PLAYBACK_WORDS - 1);

	sample_t memory [MEMORY_WORDS];

	logic write_enable;
	address_t write_address;
	sample_t write_data;
	address_t play_address;

	// merged write port with the loader first
	// host writes are lost for the whole fill
	always_comb begin
		write_enable = 1'b0;
		write_address = fill_address;
		write_data = fill_data;
		if (fill_strobe) begin
			write_enable = 1'b1;
		end else if (host_write_strobe && !loading) begin
			write_enable = 1'b1;
			write_address = host_address;
			write_data = host_data;
		end
	end

	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[write_address] <= write_data;
		end
	end

	// play address sits at 0 through the fill
	// so playback restarts at 0 once loaded pulses
	always_ff @(posedge clock) begin
		if (reset) begin
			play_address <= '0;
			read_strobe <= 1'b0;
		end else begin
			read_strobe <= word_request;
			if (loading) begin
				play_address <= '0;
			end else if (word_request) begin
				if (play_address == LAST_ADDRESS) begin
					play_address <= '0;
				end else begin
					play_address <= play_address + 1'b1;
				end
			end
		end
	end

	// read data held until the next request
	always_ff @(posedge clock) begin
		if (word_request) begin
			read_data <= memory[play_address];
		end
	end

	// host side should wait for loaded before writing
	host_write_outside_fill: assert property (
		@(posedge clock) disable iff (reset)
		!(host_write_strobe && loading)
	) else $warning("host write to %0h dropped during fill", host_address);

endmodule

//--- logic/word_serializer.sv
module word_serializer
	import fg_data_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic loading,
	input logic read_strobe,
	input sample_t read_data,
	output logic word_request,
	output logic word_strobe,
	output sample_t word_out,
	output logic bit_out
);

	// request one cycle early, word lands at phase 0
	localparam phase_t REQUEST_PHASE = phase_t'(SAMPLE_BITS - 1);
	// parked here during a fill, first request comes one cycle after loading falls
	localparam phase_t HOLD_PHASE = phase_t'(SAMPLE_BITS - 2);

	phase_t phase;
	sample_t shift_word;

	always_ff @(posedge clock) begin
		if (reset || loading) begin
			phase <= HOLD_PHASE;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	assign word_request = (phase == REQUEST_PHASE) && !loading;

	// a late answer to a request made just before a reload is ignored
	assign word_strobe = read_strobe && !loading;
	assign word_out = word_strobe ? read_data : '0;

	// msb goes out straight from read_data, the rest from the shifter
	always_ff @(posedge clock) begin
		if (reset || loading) begin
			shift_word <= '0;
		end else if (read_strobe) begin
			shift_word <= {read_data[SAMPLE_BITS-2:0], 1'b0};
		end else begin
			shift_word <= {shift_word[SAMPLE_BITS-2:0], 1'b0};
		end
	end

	always_comb begin
		if (loading) begin
			bit_out = 1'b0;
		end else if (read_strobe) begin
			bit_out = read_data[SAMPLE_BITS-1];
		end else begin
			bit_out = shift_word[SAMPLE_BITS-1];
		end
	end

	// memory answer must stay locked to the word boundary
	answer_on_boundary: assert property (
		@(posedge clock) disable iff (reset)
		read_strobe |-> (phase == '0)
	) else $error("read answer at phase %0d", phase);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
	--top-module function_generator_tb -o function_generator_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/function_generator_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
